//--- tb.f
+incdir+.
sm_pkg.sv
sm_divider.sv
sm_sequencer.sv
sm_ram.sv
sm_datapath.sv
sm_core.sv
tb_sm_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sm_core -f tb.f
./obj_dir/Vtb_sm_core 2>&1 | tee sim.log || true

if grep -q "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- tb_sm_core.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module tb_sm_core;

  localparam int CYCLE_LIMIT = 80000; // Tick wait of 32768 plus all short tests

  logic        clk;
  logic        clk_en;
  logic        reset;
  logic [7:0]  rom_data;
  logic [11:0] rom_addr;
  logic [3:0]  input_k;
  logic [3:0]  output_r;

  logic [7:0]  rom [0:4095]; // External program ROM
  logic [7:0]  prog_q [$];   // Bytes waiting to be placed
  integer      seed;
  integer      cycle_count;
  integer      err_count;

  assign rom_data = rom[rom_addr]; // Combinational ROM read

  sm_core uut (
    .clk      (clk),
    .clk_en   (clk_en),
    .reset    (reset),
    .rom_data (rom_data),
    .rom_addr (rom_addr),
    .input_k  (input_k),
    .output_r (output_r)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // Next PC, Pl shifts right with XNOR of bits 0 and 1 in at the top
  function automatic logic [11:0] pl_step(input logic [11:0] pc);
    return {pc[11:6], pc[0] ~^ pc[1], pc[5:1]};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count = err_count + 1;
      $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch");
    end
  endtask

  // Inputs move 1 ns after the edge
  task automatic step(input integer n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Class 0 bytes 00-07 are all undecoded, so the fill is NOPs
  task automatic clear_rom;
    integer i;
    for (i = 0; i < 4096; i++) begin
      rom[i] = {5'b0, i[2:0] ^ i[5:3] ^ i[8:6] ^ i[11:9]};
    end
  endtask

  // Lay queued bytes along the polynomial PC sequence
  task automatic place_prog(input logic [11:0] start);
    logic [11:0] a;
    a = start;
    while (prog_q.size() > 0) begin
      rom[a] = prog_q.pop_front();
      a = pl_step(a);
    end
  endtask

  task automatic apply_reset;
    reset = 1'b1;
    step(3);
    reset = 1'b0;
  endtask

  // Poll the address bus, bounded by a cycle limit
  task automatic wait_addr(input logic [11:0] target, input integer limit);
    integer n;
    n = 0;
    while (rom_addr !== target && n < limit) begin
      step(1);
      n++;
    end
    if (rom_addr !== target) begin
      $display("Wake from halt never came, address stuck at %0h", rom_addr);
      $display("ERRORS FOUND");
      $fatal(1, "wake wait expired");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic pc_step_after_reset;
    logic [11:0] pc;
    integer i;
    clear_rom;
    apply_reset;
    check("rom_addr after reset", rom_addr, `SM_RESET_PC);
    check("output_r after reset", output_r, 4'h0);
    pc = `SM_RESET_PC;
    for (i = 0; i < 8; i++) begin
      step(2); // One NOP
      pc = pl_step(pc);
      check("rom_addr NOP step", rom_addr, pc);
    end
    clk_en = 1'b0;
    step(3);
    check("rom_addr frozen", rom_addr, pc);
    clk_en = 1'b1;
    step(1); // Fetch only
    pc = pl_step(pc);
    clk_en = 1'b0;
    step(4);
    check("rom_addr frozen mid NOP", rom_addr, pc);
    clk_en = 1'b1;
    step(3); // Finish NOP, fetch next
    pc = pl_step(pc);
    check("rom_addr after resume", rom_addr, pc);
  endtask

  task automatic accumulator_skips;
    logic [3:0] a, b, c, k;
    logic [4:0] sum;
    integer i;
    for (i = 0; i < 6; i++) begin
      a = $random(seed);
      b = $random(seed);
      c = a ^ 4'h7;
      sum = a + b;
      k = sum[3:0] ^ 4'hA; // Differs from the sum
      clear_rom;
      prog_q = '{{`SM_CLS_LAX, a}, 8'h61, {`SM_CLS_LAX, a}, {`SM_CLS_ADX, b}, 8'h00,
                 8'h61, {`SM_CLS_LAX, a}, {`SM_CLS_ADX, b}, 8'h6A, 8'h61,
                 {`SM_CLS_LAX, a}, {`SM_CLS_LAX, c}, 8'h61};
      place_prog(`SM_RESET_PC);
      input_k = k;
      apply_reset;
      step(4);
      check("LAX then ATR", output_r, a);
      step(8);
      check("ADX sum", output_r, sum[3:0]);
      step(8); // KTA dropped on carry
      check("ADX skip", output_r, sum[4] ? sum[3:0] : k);
      step(6);
      check("chained LAX skipped", output_r, a);
    end
    input_k = 4'h0;
  endtask

  task automatic ram_access;
    logic [3:0] v, w, x, z, s;
    v = $random(seed);
    z = $random(seed);
    w = v ^ 4'h3;
    x = v ^ 4'h9;
    s = v + z; // Nibble sum, carry dropped
    clear_rom;
    prog_q = '{8'h40, {`SM_CLS_LAX, v}, 8'h10, {`SM_CLS_LAX, w}, `SM_OP_ATR,
               8'h18, `SM_OP_ATR,
               `SM_OP_TAM, {`SM_CLS_LAX, w}, `SM_OP_ATR,
               {`SM_CLS_LAX, x}, `SM_OP_TAM, `SM_OP_ATR,
               8'h4C, `SM_OP_INCB, {`SM_CLS_LAX, w}, `SM_OP_ATR,
               8'h40, {`SM_CLS_LAX, z}, `SM_OP_ADD, `SM_OP_ATR};
    place_prog(`SM_RESET_PC);
    apply_reset;
    step(10);
    check("LAX after EXC", output_r, w);
    step(4);
    check("LDA reload", output_r, v); // EXC stored v at 0
    step(6);
    check("TAM equal skips", output_r, v);
    step(6);
    check("TAM unequal runs on", output_r, x);
    step(8);
    check("INCB from F skips", output_r, x);
    step(8);
    check("ADD with RAM", output_r, s);
  endtask

  task automatic jump_targets;
    logic [5:0]  t, tpl;
    logic [1:0]  tpu;
    logic [3:0]  tpm;
    logic [11:0] dest;
    t = $random(seed);
    if (t < 6'd2) t = t + 6'd2; // Keep TL bytes off the reset byte
    tpu = $random(seed);
    tpl = $random(seed);
    tpm = $unsigned($random(seed)) % 11;
    dest = `SM_RESET_PC;
    dest[5:0] = t; // Same page, Pl from T
    clear_rom;
    rom[`SM_RESET_PC] = {2'b10, t};
    prog_q = '{{`SM_CLS_TL, tpm}, {tpu, tpl}};
    place_prog(dest);
    apply_reset;
    step(2);
    check("T target", rom_addr, dest);
    step(4);
    check("TL target", rom_addr, {tpu, tpm, tpl});
  endtask

  task automatic halt_and_wake;
    logic [3:0]  k, c;
    logic [11:0] held;
    k = $random(seed);
    if (k == 4'h0) k = 4'h1;
    c = k ^ 4'h6;
    clear_rom;
    rom[`SM_RESET_PC] = `SM_OP_CEND;
    prog_q = '{`SM_OP_KTA, `SM_OP_ATR, `SM_OP_IDIV, `SM_OP_TF4, {`SM_CLS_LAX, c},
               `SM_OP_ATR, `SM_OP_CEND};
    place_prog(`SM_WAKE_PC);
    input_k = 4'h0;
    apply_reset;
    step(4); // CEND, then into halt
    held = rom_addr;
    step(2100); // Divider passes the F4 tap, only IDIV clears it
    check("rom_addr in halt", rom_addr, held);
    input_k = k;
    wait_addr(pl_step(`SM_WAKE_PC), 8); // KTA fetched at the wake PC
    step(3);
    check("KTA after wake", output_r, k);
    input_k = 4'h0;
    step(8);
    check("TF4 after IDIV", output_r, c);
    step(4);
    held = rom_addr;
    step(10);
    check("rom_addr in second halt", rom_addr, held);
    wait_addr(pl_step(`SM_WAKE_PC), 32768 + 64); // One-second tick
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    clk         = 1'b0;
    clk_en      = 1'b1;
    reset       = 1'b1;
    input_k     = 4'h0;
    seed        = 32'h8edc;
    cycle_count = 0;
    err_count   = 0;
    pc_step_after_reset;
    accumulator_skips;
    ram_access;
    jump_targets;
    halt_and_wake;
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sm_core.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module sm_core (
  input  logic                  clk,
  input  logic                  clk_en,   // 32.768 kHz pace
  input  logic                  reset,
  input  logic [7:0]            rom_data, // External ROM, combinational
  output logic [`SM_ROM_AW-1:0] rom_addr,
  input  logic [3:0]            input_k,  // K1-4
  output logic [3:0]            output_r  // R port, full Acc
);
  import sm_pkg::*;

  stage_t                stage;
  logic                  skip_req;
  logic                  halt_req;
  logic                  idiv;
  logic                  f4;
  logic                  sec_tick;
  logic [`SM_RAM_AW-1:0] ram_addr;
  logic                  ram_wren;
  logic [3:0]            ram_wdata;
  logic [3:0]            ram_rdata;

  sm_divider u_divider (
    .clk      (clk),
    .clk_en   (clk_en),
    .reset    (reset),
    .idiv     (idiv),
    .f4       (f4),
    .sec_tick (sec_tick)
  );

  // Stage control and wake
  sm_sequencer u_sequencer (
    .clk      (clk),
    .clk_en   (clk_en),
    .reset    (reset),
    .opcode   (rom_data),
    .skip_req (skip_req),
    .halt_req (halt_req),
    .input_k  (input_k),
    .sec_tick (sec_tick),
    .stage    (stage)
  );

  sm_ram u_ram (
    .clk   (clk),
    .addr  (ram_addr),
    .wren  (ram_wren),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  sm_datapath u_datapath (
    .clk       (clk),
    .clk_en    (clk_en),
    .reset     (reset),
    .stage     (stage),
    .opcode    (rom_data),
    .ram_rdata (ram_rdata),
    .input_k   (input_k),
    .f4        (f4),
    .rom_addr  (rom_addr),
    .ram_addr  (ram_addr),
    .ram_wren  (ram_wren),
    .ram_wdata (ram_wdata),
    .skip_req  (skip_req),
    .halt_req  (halt_req),
    .idiv      (idiv),
    .output_r  (output_r)
  );

endmodule

//--- sm_datapath.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module sm_datapath (
  input  logic                  clk,
  input  logic                  clk_en,
  input  logic                  reset,
  input  sm_pkg::stage_t        stage,
  input  sm_pkg::opcode_t       opcode,
  input  logic [3:0]            ram_rdata,
  input  logic [3:0]            input_k,
  input  logic                  f4,
  output logic [`SM_ROM_AW-1:0] rom_addr,
  output logic [`SM_RAM_AW-1:0] ram_addr,
  output logic                  ram_wren,
  output logic [3:0]            ram_wdata,
  output logic                  skip_req,
  output logic                  halt_req,
  output logic                  idiv,
  output logic [3:0]            output_r
);
  import sm_pkg::*;

  // Program counter, page Pu/Pm and polynomial Pl
  logic [1:0] pu;
  logic [3:0] pm;
  logic [5:0] pl;

  logic [3:0] acc;
  logic       carry;     // ADX carry out, consumed as a skip
  logic [2:0] bm;        // RAM file
  logic [3:0] bl;        // RAM nibble
  logic       skip_next; // TAM, INCB, TF4 result
  logic       lax_chain; // Last executed was LAX
  opcode_t    ir;        // Byte being performed, TL first byte in exec2

  logic [5:0] pl_next;
  logic [4:0] adx_sum;
  logic [3:0] add_sum;
  logic       is_exec;
  logic       is_ram_op;

  //////////////////////////////////////////////////////////////////////
  // Combinational

  assign pl_next   = {pl[0] ~^ pl[1], pl[5:1]}; // Only Pl moves
  assign adx_sum   = {1'b0, acc} + {1'b0, ir.nib.imm};
  assign add_sum   = acc + ram_rdata;
  assign is_exec   = stage == stg_exec;
  assign is_ram_op = ir.nib.cls == `SM_CLS_RAM
                     && (ir.nib.imm[3:2] == `SM_SUB_EXC || ir.nib.imm[3:2] == `SM_SUB_LDA);

  assign rom_addr  = {pu, pm, pl};
  assign ram_addr  = {bm, bl};
  assign ram_wdata = acc; // EXC stores Acc

  // One write per enabled exec cycle
  assign ram_wren = clk_en && is_exec && ir.nib.cls == `SM_CLS_RAM
                    && ir.nib.imm[3:2] == `SM_SUB_EXC;

  assign halt_req = is_exec && ir == `SM_OP_CEND;
  assign idiv     = is_exec && ir == `SM_OP_IDIV;

  // Sampled in fetch, opcode is the byte at PC
  assign skip_req = skip_next | carry | (lax_chain && opcode.nib.cls == `SM_CLS_LAX);

  // Latch byte at fetch, held through load2 for TL
  always_ff @(posedge clk) begin
    if (clk_en && stage == stg_fetch) begin
      ir <= opcode;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk) begin
    if (reset) begin
      {pu, pm, pl} <= `SM_RESET_PC;
      acc          <= 4'h0;
      carry        <= 1'b0;
      bm           <= 3'h0;
      bl           <= 4'h0;
      skip_next    <= 1'b0;
      lax_chain    <= 1'b0;
      output_r     <= 4'h0;
    end else if (clk_en) begin
      case (stage)
        stg_fetch: begin
          pl        <= pl_next;
          skip_next <= 1'b0;
          carry     <= 1'b0;
          lax_chain <= lax_chain && opcode.nib.cls == `SM_CLS_LAX; // Skipped LAX keeps it
        end
        stg_exec: begin
          if (ir.jmp.cls == `SM_JCLS_T) begin
            pl <= ir.jmp.pl; // T xy, within page
          end else begin
            case (ir.nib.cls)
              `SM_CLS_LAX: begin
                acc       <= ir.nib.imm;
                lax_chain <= 1'b1;
              end
              `SM_CLS_ADX: {carry, acc} <= adx_sum;
              `SM_CLS_LB: begin
                bm[1:0] <= ir.nib.imm[1:0];
                // High Bl bits follow any set bit of the Bl field
                bl <= {{2{|ir.nib.imm[3:2]}}, ir.nib.imm[3:2]};
              end
              `SM_CLS_RAM: begin
                if (is_ram_op) begin
                  acc     <= ram_rdata; // EXC writes old Acc in parallel
                  bm[1:0] <= bm[1:0] ^ ir.nib.imm[1:0];
                end
              end
              default: begin
                case (ir)
                  `SM_OP_ADD:  acc <= add_sum;
                  `SM_OP_TAM:  skip_next <= acc == ram_rdata;
                  `SM_OP_INCB: begin
                    bl        <= bl + 1'b1;
                    skip_next <= bl == 4'hF;
                  end
                  `SM_OP_KTA:  acc <= input_k;
                  `SM_OP_ATR:  output_r <= acc;
                  `SM_OP_TF4:  skip_next <= f4;
                  default: ; // NOP, CEND, IDIV, TL first byte
                endcase
              end
            endcase
          end
        end
        stg_exec2: begin
          pl <= pl_next;
          // TL xyz, target overrides the step, Pm B and up not decoded
          if (ir.nib.imm <= `SM_TL_PM_MAX) begin
            {pu, pm, pl} <= {opcode.jmp.cls, ir.nib.imm, opcode.jmp.pl};
          end
        end
        stg_halt: {pu, pm, pl} <= `SM_WAKE_PC; // Resume point after wake
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Writes only in exec, and the instruction ends right after
  a_wren_exec: assert property (@(posedge clk) disable iff (reset)
    ram_wren |-> (stage == stg_exec ##1 stage == stg_fetch));

endmodule

//--- sm_ram.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module sm_ram (
  input  logic                  clk,
  input  logic [`SM_RAM_AW-1:0] addr,
  input  logic                  wren,
  input  logic [3:0]            wdata,
  output logic [3:0]            rdata
);

  // Eight files of sixteen nibbles, {Bm, Bl}
  logic [3:0] mem [0:(1 << `SM_RAM_AW)-1];

  // Write on the edge, caller qualifies with clk_en
  always_ff @(posedge clk) begin
    if (wren) begin
      mem[addr] <= wdata;
    end
  end

  // Read is combinational, EXC sees the old value on its write edge
  assign rdata = mem[addr];

endmodule

//--- sm_sequencer.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module sm_sequencer (
  input  logic            clk,
  input  logic            clk_en,
  input  logic            reset,
  input  sm_pkg::opcode_t opcode,
  input  logic            skip_req,
  input  logic            halt_req,
  input  logic [3:0]      input_k,
  input  logic            sec_tick,
  output sm_pkg::stage_t  stage
);
  import sm_pkg::*;

  logic halt_pend; // CEND performed, halt at next fetch
  logic wake_q;    // K pressed or second elapsed
  logic tl_q;      // Fetched byte opens a TL

  always_ff @(posedge clk) begin
    if (reset) begin
      stage     <= stg_fetch;
      halt_pend <= 1'b0;
      wake_q    <= 1'b0;
      tl_q      <= 1'b0;
    end else if (clk_en) begin
      wake_q <= (input_k != 4'h0) | sec_tick;
      if (halt_req) begin
        halt_pend <= 1'b1;
      end

      case (stage)
        stg_fetch: begin
          tl_q <= opcode.nib.cls == `SM_CLS_TL; // Opcode is the byte at PC here
          if (halt_pend) begin
            stage <= stg_halt;
          end else if (skip_req) begin
            stage <= stg_skip;
          end else begin
            stage <= stg_exec;
          end
        end
        stg_exec:  stage <= tl_q ? stg_load2 : stg_fetch;
        stg_load2: stage <= stg_exec2;
        stg_exec2: stage <= stg_fetch;
        stg_skip:  stage <= stg_fetch;
        stg_halt: begin
          if (wake_q) begin
            stage     <= stg_fetch; // Datapath already sits at the wake PC
            halt_pend <= 1'b0;
          end
        end
        default: stage <= stg_fetch;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  a_stage_legal: assert property (@(posedge clk) disable iff (reset)
    stage inside {stg_fetch, stg_exec, stg_load2, stg_exec2, stg_skip, stg_halt});

  // Halt exit needs a registered wake
  a_halt_wake: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && $past(stage) == stg_halt && stage != stg_halt) |-> $past(wake_q));

  a_load2_after_exec: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && stage == stg_load2 && $past(stage) != stg_load2)
      |-> $past(stage) == stg_exec);

endmodule

//--- sm_divider.sv
`timescale 1ns/1ps
`include "sm_defines.svh"

module sm_divider (
  input  logic clk,
  input  logic clk_en,
  input  logic reset,
  input  logic idiv,
  output logic f4,
  output logic sec_tick
);

  // Time base, one count per enabled cycle
  logic [`SM_DIV_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clk_en) begin
      if (idiv) begin
        count <= '0; // IDIV restarts the second
      end else begin
        count <= count + 1'b1; // Wraps once per second
      end
    end
  end

  // Tap for TF4
  assign f4 = count[`SM_F4_BIT];

  // High on the last count, so the wrap happens on this cycle's edge
  // A pending IDIV clears instead of wrapping
  assign sec_tick = (&count) & ~idiv;

endmodule

//--- sm_pkg.sv
package sm_pkg;

  //////////////////////////////////////////////////////////////////////
  // ROM byte, decoded through two views

  typedef union packed {
    // Class nibble and immediate nibble
    struct packed {
      logic [3:0] cls;
      logic [3:0] imm;
    } nib;
    // Short jump, also the second byte of TL
    struct packed {
      logic [1:0] cls; // 2'b10 for T, Pu for TL
      logic [5:0] pl;  // Target Pl
    } jmp;
  } opcode_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction stages

  typedef enum logic [2:0] {
    stg_fetch = 3'd0, // Step PC, choose exec, skip or halt
    stg_exec  = 3'd1, // Decode and perform
    stg_load2 = 3'd2, // Second byte settles on the bus
    stg_exec2 = 3'd3, // Perform the two-byte instruction
    stg_skip  = 3'd4, // Byte dropped
    stg_halt  = 3'd5  // Stopped by CEND
  } stage_t;

endpackage

//--- sm_defines.svh
`ifndef SM_DEFINES_SVH
`define SM_DEFINES_SVH

// Bus widths
`define SM_ROM_AW 12 // Pu 2, Pm 4, Pl 6
`define SM_RAM_AW 7  // Bm 3, Bl 4
`define SM_DIV_W  15 // 32.768 kHz down to 1 Hz
`define SM_F4_BIT 11 // Divider tap tested by TF4

// PC as {Pu, Pm, Pl}
`define SM_RESET_PC 12'hDC0 // 3_7_00
`define SM_WAKE_PC  12'h400 // 1_0_00

// Instruction classes in the high nibble
`define SM_CLS_RAM 4'h1 // EXC, EXCI, LDA, EXCD
`define SM_CLS_LAX 4'h2
`define SM_CLS_ADX 4'h3
`define SM_CLS_LB  4'h4
`define SM_CLS_TL  4'h7 // First byte of TL
`define SM_SUB_EXC 2'b00 // Bits 3-2 inside class 1
`define SM_SUB_LDA 2'b10
`define SM_JCLS_T  2'b10 // T xy, top two bits
`define SM_TL_PM_MAX 4'hA // Highest Pm reachable by TL

// Single-byte opcodes
`define SM_OP_ADD  8'h08
`define SM_OP_TAM  8'h53
`define SM_OP_CEND 8'h5D
`define SM_OP_ATR  8'h61
`define SM_OP_INCB 8'h64
`define SM_OP_IDIV 8'h65
`define SM_OP_TF4  8'h69
`define SM_OP_KTA  8'h6A

`endif
